/* include/iq_dump_cfg.svh */
`ifndef IQ_DUMP_CFG_SVH
`define IQ_DUMP_CFG_SVH

// clocks per input bit on sig_i and sig_q
`define SAMPLE_DIV 4

// clocks per uart bit, kept small for short sims
`define BAUD_DIV 8

// capture buffer geometry
`define BUF_DEPTH 128
`define BUF_AW 7

`endif

/* hw/iq_dump_pkg.sv */
package iq_dump_pkg;

    // one deserialized i/q pair
    typedef struct packed {
        logic [7:0] q;  // upper byte
        logic [7:0] i;  // lower byte
    } iq_sample_t;

    // buffer word, written as a sample and read back as two uart bytes
    typedef union packed {
        iq_sample_t      sample;  // write side view
        logic [1:0][7:0] bytes;   // [0] is i, [1] is q
    } iq_word_u;

endpackage

/* hw/iq_sampler.sv */
`timescale 1ns/1ps
`include "iq_dump_cfg.svh"

module iq_sampler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  logic                    enable,
    input  logic                    sig_i,
    input  logic                    sig_q,
    output iq_dump_pkg::iq_sample_t sample,
    output logic                    sample_valid
);

    localparam int DW = ($clog2(`SAMPLE_DIV) < 1) ? 1 : $clog2(`SAMPLE_DIV);
    localparam logic [DW-1:0] DIV_LAST = DW'(`SAMPLE_DIV - 1);
    localparam logic [DW-1:0] DIV_MID  = DW'(`SAMPLE_DIV / 2);

    logic [DW-1:0] div_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    i_sr;
    logic [7:0]    q_sr;
    logic          tick;

    assign tick = enable && (div_cnt == DIV_MID);  // middle of each input bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (clear) begin
            div_cnt <= '0;  // realign to the source on re-arm
        end else if (enable) begin
            if (div_cnt == DIV_LAST) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end else if (clear) begin
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= tick && (bit_cnt == 3'd7);
            if (tick) begin
                bit_cnt <= bit_cnt + 3'd1;  // wraps after a full byte
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick) begin
            i_sr <= {i_sr[6:0], sig_i};  // msb arrives first
            q_sr <= {q_sr[6:0], sig_q};
        end
    end

    assign sample = {q_sr, i_sr};

endmodule

/* hw/capture_buffer.sv */
`timescale 1ns/1ps
`include "iq_dump_cfg.svh"

module capture_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  iq_dump_pkg::iq_sample_t sample,
    input  logic                    sample_valid,
    output logic                    full,
    input  logic [`BUF_AW-1:0]      rd_addr,
    output iq_dump_pkg::iq_word_u   rd_data
);

    import iq_dump_pkg::*;

    localparam logic [`BUF_AW:0] PTR_END  = (`BUF_AW + 1)'(`BUF_DEPTH);
    localparam logic [`BUF_AW:0] PTR_LAST = (`BUF_AW + 1)'(`BUF_DEPTH - 1);

    iq_word_u         mem [`BUF_DEPTH];
    iq_word_u         wr_word;
    logic [`BUF_AW:0] wr_ptr;
    logic             wr_en;

    assign wr_en = sample_valid && (wr_ptr != PTR_END);  // one shot, stops when full

    always_comb begin
        wr_word.sample = sample;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else if (clear) begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end else begin
            full <= wr_en && (wr_ptr == PTR_LAST);  // pulse on last word
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[`BUF_AW-1:0]] <= wr_word;
        end
    end

    // read port runs every cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* hw/dump_sequencer.sv */
`timescale 1ns/1ps
`include "iq_dump_cfg.svh"

module dump_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  go,
    output logic [`BUF_AW-1:0]    rd_addr,
    input  iq_dump_pkg::iq_word_u rd_data,
    output byte                   tx_data,
    output logic                  tx_start,
    input  logic                  tx_busy,
    output logic                  done
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_READ    = 3'd1;
    localparam logic [2:0] S_SEND_LO = 3'd2;
    localparam logic [2:0] S_SEND_HI = 3'd3;
    localparam logic [2:0] S_FINISH  = 3'd4;

    localparam logic [`BUF_AW-1:0] LAST_ADDR = `BUF_AW'(`BUF_DEPTH - 1);

    logic [2:0] state;
    logic       tx_free;
    logic       send_lo;
    logic       send_hi;

    // busy only rises the cycle after a start, so block on our own start too
    assign tx_free = !tx_busy && !tx_start;
    assign send_lo = (state == S_SEND_LO) && tx_free;
    assign send_hi = (state == S_SEND_HI) && tx_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            rd_addr  <= '0;
            tx_start <= 1'b0;
            done     <= 1'b0;
        end else begin
            tx_start <= send_lo || send_hi;
            done     <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (go) begin
                        rd_addr <= '0;
                        state   <= S_READ;
                    end
                end
                S_READ: state <= S_SEND_LO;  // one clock read latency
                S_SEND_LO: begin
                    if (send_lo) begin
                        state <= S_SEND_HI;
                    end
                end
                S_SEND_HI: begin
                    if (send_hi) begin
                        if (rd_addr == LAST_ADDR) begin
                            state <= S_FINISH;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;  // next read overlaps this frame
                            state   <= S_SEND_LO;
                        end
                    end
                end
                S_FINISH: begin
                    if (tx_free) begin
                        done  <= 1'b1;  // last stop bit has ended
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send_lo) begin
            tx_data <= rd_data.bytes[0];  // i byte
        end else if (send_hi) begin
            tx_data <= rd_data.bytes[1];  // q byte
        end
    end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`include "iq_dump_cfg.svh"

module uart_tx (
    input  logic clk,
    input  logic rst_n,
    input  byte  tx_data,
    input  logic tx_start,
    output logic tx_busy,
    output logic tx
);

    localparam int BW = ($clog2(`BAUD_DIV) < 1) ? 1 : $clog2(`BAUD_DIV);
    localparam logic [BW-1:0] BAUD_LAST = BW'(`BAUD_DIV - 1);

    logic [BW-1:0] baud_cnt;
    logic [3:0]    bit_idx;
    logic [9:0]    frame;  // stop, data lsb first, start
    logic          bit_end;

    assign bit_end = tx_busy && (baud_cnt == BAUD_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            frame    <= '1;  // line idles high
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_data, 1'b0};
                tx_busy  <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;  // end of stop bit, frame[0] stays high
            end else begin
                bit_idx <= bit_idx + 4'd1;
                frame   <= {1'b1, frame[9:1]};
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign tx = frame[0];

endmodule

/* hw/iq_dump_top.sv */
`timescale 1ns/1ps
`include "iq_dump_cfg.svh"

module iq_dump_top (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic sig_i,
    input  logic sig_q,
    output logic tx,
    output logic capturing,
    output logic dumping
);

    import iq_dump_pkg::*;

    localparam logic [1:0] MODE_IDLE    = 2'd0;
    localparam logic [1:0] MODE_CAPTURE = 2'd1;
    localparam logic [1:0] MODE_DUMP    = 2'd2;

    logic [1:0]         mode;
    logic               arm;
    logic               go;
    logic               done;
    logic               full;
    logic               sample_valid;
    logic               tx_start;
    logic               tx_busy;
    logic [`BUF_AW-1:0] rd_addr;
    iq_sample_t         sample;
    iq_word_u           rd_data;
    byte                tx_data;

    assign arm       = start && (mode == MODE_IDLE);  // start ignored while busy
    assign go        = full && (mode == MODE_CAPTURE);
    assign capturing = (mode == MODE_CAPTURE);
    assign dumping   = (mode == MODE_DUMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_IDLE;
        end else begin
            case (mode)
                MODE_IDLE:    if (arm)  mode <= MODE_CAPTURE;
                MODE_CAPTURE: if (full) mode <= MODE_DUMP;
                MODE_DUMP:    if (done) mode <= MODE_IDLE;
                default:      mode <= MODE_IDLE;
            endcase
        end
    end

    iq_sampler u_sampler (
        .clk(clk), .rst_n(rst_n), .clear(arm), .enable(capturing),
        .sig_i(sig_i), .sig_q(sig_q), .sample(sample), .sample_valid(sample_valid)
    );

    capture_buffer u_buffer (
        .clk(clk), .rst_n(rst_n), .clear(arm), .sample(sample),
        .sample_valid(sample_valid), .full(full), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    dump_sequencer u_sequencer (
        .clk(clk), .rst_n(rst_n), .go(go), .rd_addr(rd_addr), .rd_data(rd_data),
        .tx_data(tx_data), .tx_start(tx_start), .tx_busy(tx_busy), .done(done)
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst_n(rst_n), .tx_data(tx_data), .tx_start(tx_start),
        .tx_busy(tx_busy), .tx(tx)
    );

endmodule

/* testbench/iq_dump_assertions.sv */
`timescale 1ns/1ps

module iq_dump_assertions (
    input logic clk,
    input logic rst_n,
    input logic tx_start,
    input logic tx_busy,
    input logic sample_valid,
    input logic capturing,
    input logic dumping,
    input logic tx
);

    // a new byte only goes to an idle transmitter
    start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(tx_start && tx_busy))
        else $error("tx_start raised while tx_busy is high");

    // dump work stays inside dump mode, apart from capture
    tx_in_dump: assert property (@(posedge clk) disable iff (!rst_n)
        tx_busy |-> (dumping && !capturing))
        else $error("transmitter busy outside dump mode");

    valid_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> capturing)
        else $error("sample_valid outside capture");

    line_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
        else $error("tx low while transmitter is idle");

endmodule

bind iq_dump_top iq_dump_assertions u_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .tx_start(tx_start),
    .tx_busy(tx_busy),
    .sample_valid(sample_valid),
    .capturing(capturing),
    .dumping(dumping),
    .tx(tx)
);

/* testbench/iq_dump_tb.sv */
`timescale 1ns/1ps
`include "iq_dump_cfg.svh"

module iq_dump_tb;

    import iq_dump_pkg::*;

    localparam int SD            = `SAMPLE_DIV;
    localparam int B             = `BAUD_DIV;
    localparam int DEPTH         = `BUF_DEPTH;
    localparam int FRAME_SAMPLES = 10 * B - 1;  // stops one clock short of the frame end
    localparam int CAPTURE_LIMIT = DEPTH * 8 * SD + 200;
    localparam int RX_LIMIT      = 20 * B;
    localparam int PULSE_WORD    = 40;

    // stimulus table, each entry is {q, i}
    localparam logic [15:0] PATTERN [8] = '{
        16'h00_FF, 16'hFF_00, 16'h80_01, 16'h01_80,
        16'hA5_5A, 16'h5A_A5, 16'hC3_3C, 16'h7E_E7
    };

    logic clk;
    logic rst_n;
    logic start;
    logic sig_i;
    logic sig_q;
    logic tx;
    logic capturing;
    logic dumping;

    iq_sample_t expected_words [DEPTH];
    int         mismatch_count;
    int         failure_count;
    int         rx_count;
    bit         timed_out;
    integer     seed;

    iq_dump_top UUT (
        .clk(clk),
        .rst_n(rst_n),
        .start(start),
        .sig_i(sig_i),
        .sig_q(sig_q),
        .tx(tx),
        .capturing(capturing),
        .dumping(dumping)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic byte expected_byte(input int index);
        iq_sample_t w;
        w = expected_words[index / 2];
        if (index % 2 == 0) begin
            return w.i;  // i goes out first
        end else begin
            return w.q;
        end
    endfunction

    task automatic load_pattern();
        for (int w = 0; w < DEPTH; w++) begin
            expected_words[w] = PATTERN[w % 8];
        end
    endtask

    task automatic load_random();
        logic [31:0] r;
        for (int w = 0; w < DEPTH; w++) begin
            r = $random(seed);
            expected_words[w] = r[15:0];
        end
    endtask

    task automatic check_idle(input int cycles);
        bit bad;
        bad = 1'b0;
        for (int n = 0; n < cycles && !bad; n++) begin
            @(posedge clk);
            if (tx !== 1'b1 || capturing !== 1'b0 || dumping !== 1'b0) begin
                $display("MISMATCH at %0t: idle line tx=%b capturing=%b dumping=%b",
                         $time, tx, capturing, dumping);
                mismatch_count++;
                bad = 1'b1;
            end
        end
    endtask

    task automatic wait_dumping(input logic level, input int limit, input string what);
        int n;
        if (timed_out) return;
        n = 0;
        while (dumping !== level && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (dumping !== level) begin
            $display("ERROR: %s did not happen within %0d cycles", what, limit);
            failure_count++;
            timed_out = 1'b1;
        end
    endtask

    // serializes every buffer word msb first, one bit per SAMPLE_DIV clocks
    task automatic drive_stream(input int pulse_word);
        iq_sample_t w;
        if (timed_out) return;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;  // start taken on this edge
        for (int word = 0; word < DEPTH; word++) begin
            w = expected_words[word];
            for (int b = 7; b >= 0; b--) begin
                for (int c = 0; c < SD; c++) begin
                    @(posedge clk);
                    if (word == 0 && b == 7 && c == 0 && capturing !== 1'b1) begin
                        $display("MISMATCH at %0t: capturing did not rise after start", $time);
                        mismatch_count++;
                    end
                    if (c == 0) begin
                        sig_i <= w.i[b];
                        sig_q <= w.q[b];
                    end
                    start <= (word == pulse_word) && (b == 4) && (c == 0);
                end
            end
        end
    endtask

    task automatic pulse_start_in_dump();
        if (timed_out) return;
        repeat (300) @(posedge clk);
        if (dumping !== 1'b1) begin
            $display("MISMATCH at %0t: dump ended before the extra start pulse", $time);
            mismatch_count++;
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // uart receive model, samples tx once per clock over one frame
    task automatic receive_frame(input int index);
        logic samples [10 * B];
        byte  data;
        byte  want;
        bit   frame_ok;
        int   n;
        if (timed_out) return;
        n = 0;
        while (tx !== 1'b0 && n < RX_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (tx !== 1'b0) begin
            $display("ERROR: no start bit for byte %0d within %0d cycles", index, RX_LIMIT);
            failure_count++;
            timed_out = 1'b1;
            return;
        end
        for (int k = 0; k < FRAME_SAMPLES; k++) begin
            if (k > 0) @(posedge clk);
            samples[k] = tx;
        end
        for (int k = 0; k < 8; k++) begin
            data[k] = samples[B * (k + 1) + B / 2];  // mid-bit, lsb first
        end
        frame_ok = 1'b1;
        for (int k = 0; k < B - 1; k++) begin
            if (samples[k] !== 1'b0) frame_ok = 1'b0;
        end
        if (data[0] && samples[B + 1] !== 1'b1) frame_ok = 1'b0;  // start too long
        if (!data[7] && samples[9 * B - 2] !== 1'b0) frame_ok = 1'b0;  // stop too early
        for (int k = 9 * B; k < FRAME_SAMPLES; k++) begin
            if (samples[k] !== 1'b1) frame_ok = 1'b0;
        end
        if (!frame_ok) begin
            $display("MISMATCH at %0t: byte %0d has a bad start or stop bit", $time, index);
            mismatch_count++;
        end
        want = expected_byte(index);
        if (data !== want) begin
            $display("MISMATCH at %0t: byte %0d got %h expected %h", $time, index, data, want);
            mismatch_count++;
        end
        rx_count++;
    endtask

    task automatic receive_all();
        for (int n = 0; n < 2 * DEPTH && !timed_out; n++) begin
            receive_frame(n);
        end
    endtask

    task automatic check_line_quiet(input int cycles);
        bit bad;
        bad = 1'b0;
        for (int n = 0; n < cycles && !bad; n++) begin
            @(posedge clk);
            if (tx !== 1'b1) begin
                $display("MISMATCH at %0t: extra byte after %0d bytes", $time, rx_count);
                mismatch_count++;
                bad = 1'b1;
            end
        end
    endtask

    task automatic capture_and_dump(input bit pulse_in_dump, input int pulse_word);
        rx_count = 0;
        fork
            drive_stream(pulse_word);
            begin
                wait_dumping(1'b1, CAPTURE_LIMIT, "dumping rise");
                fork
                    receive_all();
                    if (pulse_in_dump) pulse_start_in_dump();
                join
                wait_dumping(1'b0, RX_LIMIT, "dumping fall");
                if (!timed_out) check_line_quiet(40 * B);
            end
        join
        if (!timed_out && rx_count != 2 * DEPTH) begin
            $display("MISMATCH at %0t: received %0d bytes expected %0d",
                     $time, rx_count, 2 * DEPTH);
            mismatch_count++;
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        start          = 1'b0;
        sig_i          = 1'b0;
        sig_q          = 1'b0;
        mismatch_count = 0;
        failure_count  = 0;
        rx_count       = 0;
        timed_out      = 1'b0;
        seed           = 32'h98e647b3;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        check_idle(100);

        load_pattern();
        capture_and_dump(1'b1, PULSE_WORD);  // stray starts in capture and dump

        // re-arm with fresh data
        if (!timed_out) begin
            load_random();
            capture_and_dump(1'b0, -1);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* iq_dump.f */
+incdir+include
hw/iq_dump_pkg.sv
hw/iq_sampler.sv
hw/capture_buffer.sv
hw/dump_sequencer.sv
hw/uart_tx.sv
hw/iq_dump_top.sv
testbench/iq_dump_assertions.sv
testbench/iq_dump_tb.sv
